// File: common/sifhCfgPkg.sv
// Sample, bin and counter widths for the histogram peak finder
// Derived window constants and default pass sizes
package sifhCfgPkg;

    // ********************
    // Sample and bin widths
    // ********************
    localparam int sampleBits   = 12;           // One timestamp sample
    localparam int binBits      = 6;            // Bin address bits
    localparam int binsPerPixel = 1 << binBits;
    localparam int countBits    = 8;            // Saturating bin counter
    localparam int residueBits  = sampleBits - binBits;

    // Fine window geometry
    localparam int halfWindow   = 1 << (binBits - 1);
    localparam int windowSpan   = 2 * halfWindow;
    localparam int maxCode      = (1 << sampleBits) - 1;

    // Highest legal lower bound of a fine window
    localparam int topLowBound  = maxCode - windowSpan + 1;

    // ********************
    // Default pass sizes
    // ********************
    localparam int defaultPixels          = 4;
    localparam int defaultSamplesPerPixel = 4;
    localparam int defaultAcquisitions    = 8;

    // Index width for a counter that runs 0 .. n-1
    function automatic int idxWidth(input int n);
        int width;
        if (n > 1) begin
            width = $clog2(n);
        end
        else begin
            width = 1;                          // Keep at least one bit
        end
        return width;
    endfunction

endpackage

// File: common/sifhTypesPkg.sv
// Pass selector enum
// Sample word union with coarse and raw views
package sifhTypesPkg;

    // Which histogram pass is running
    typedef enum logic {
        passCoarse = 1'b0,
        passFine   = 1'b1
    } passSel_t;

    // ********************
    // Sample word views
    // ********************

    // Coarse split of a sample into top bin bits and the rest
    typedef struct packed {
        logic [sifhCfgPkg::binBits-1:0]     coarseBin;
        logic [sifhCfgPkg::residueBits-1:0] residue;
    } coarseView_t;

    // Same word read either as coarse fields or as a plain code
    typedef union packed {
        coarseView_t                       coarse;
        logic [sifhCfgPkg::sampleBits-1:0] raw;
    } sampleWord_t;

endpackage

// File: histogram/dataFilter.sv
// Sample decoder for the coarse and fine passes
// Produces the bin address and the keep flag for the histogram builder
`timescale 1ns/10ps

module dataFilter (
    input  logic [sifhCfgPkg::sampleBits-1:0] data,
    input  sifhTypesPkg::passSel_t            pass,
    input  logic [sifhCfgPkg::sampleBits-1:0] winLow,
    input  logic [sifhCfgPkg::sampleBits-1:0] winHigh,
    output logic [sifhCfgPkg::binBits-1:0]    binAddr,
    output logic                              binKeep
);
    import sifhCfgPkg::*;
    import sifhTypesPkg::*;

    sampleWord_t           word;
    logic [sampleBits-1:0] offset;       // Distance from window floor
    logic                  inWindow;

    // ********************
    // Decode
    // ********************
    always_comb begin
        word.raw = data;
        offset   = word.raw - winLow;
        inWindow = (word.raw >= winLow) && (word.raw <= winHigh);

        if (pass == passCoarse) begin
            // Top bits pick the coarse bin, nothing is dropped
            binAddr = word.coarse.coarseBin;
            binKeep = 1'b1;
        end
        else begin
            binKeep = inWindow;
            if (inWindow) begin
                binAddr = offset[binBits-1:0];  // Window is 2^binBits wide
            end
            else begin
                binAddr = '0;
            end
        end
    end

endmodule

// File: histogram/histogramBuilder.sv
// Per-pixel bin counters with lazy clear
// Sample, pixel and acquisition counters and the post-pass busy gap
`timescale 1ns/10ps

module histogramBuilder #(
    parameter int pixelNum            = sifhCfgPkg::defaultPixels,
    parameter int samplesPerPixel     = sifhCfgPkg::defaultSamplesPerPixel,
    parameter int acquisitionsPerPass = sifhCfgPkg::defaultAcquisitions
) (
    input  logic                                      clk,
    input  logic                                      combin_res,
    input  logic                                      wrEn,
    input  logic [sifhCfgPkg::binBits-1:0]            binAddr,
    input  logic                                      binKeep,
    input  sifhTypesPkg::passSel_t                    pass,
    output logic [sifhCfgPkg::idxWidth(pixelNum)-1:0] curPixel,
    output logic                                      countStrobe,
    output logic [sifhCfgPkg::idxWidth(pixelNum)-1:0] countPixel,
    output logic [sifhCfgPkg::binBits-1:0]            countBin,
    output logic [sifhCfgPkg::countBits-1:0]          countValue,
    output logic                                      passEnd,
    output logic                                      busy
);
    import sifhCfgPkg::*;
    import sifhTypesPkg::*;

    localparam int pixBits = idxWidth(pixelNum);
    localparam int smpBits = idxWidth(samplesPerPixel);
    localparam int acqBits = idxWidth(acquisitionsPerPass);

    localparam logic [pixBits-1:0]   lastPixel  = pixBits'(pixelNum - 1);
    localparam logic [smpBits-1:0]   lastSample = smpBits'(samplesPerPixel - 1);
    localparam logic [acqBits-1:0]   lastAcq    = acqBits'(acquisitionsPerPass - 1);
    localparam logic [countBits-1:0] countMax   = '1;

    // Counter array and its valid bits
    logic [countBits-1:0]                       binCount [pixelNum][binsPerPixel];
    logic [pixelNum-1:0][binsPerPixel-1:0]      binValid;

    logic [smpBits-1:0]   sampleCnt;
    logic [acqBits-1:0]   acqCnt;
    passSel_t             seenPass;      // Pass level when busy was raised
    logic                 accept;
    logic                 passLast;
    logic [countBits-1:0] oldCount;
    logic [countBits-1:0] newCount;

    always_comb begin
        accept   = wrEn && !busy;
        passLast = (sampleCnt == lastSample) && (curPixel == lastPixel)
                   && (acqCnt == lastAcq);
        // Cleared valid bit reads as an empty bin
        oldCount = binValid[curPixel][binAddr] ? binCount[curPixel][binAddr] : '0;
        newCount = (oldCount == countMax) ? oldCount : oldCount + 1'b1;
    end

    // ********************
    // Sample position
    // ********************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            curPixel  <= '0;
            acqCnt    <= '0;
            busy      <= 1'b0;
            seenPass  <= passCoarse;
        end
        else begin
            if (accept) begin
                if (sampleCnt == lastSample) begin
                    sampleCnt <= '0;
                    if (curPixel == lastPixel) begin
                        curPixel <= '0;
                        acqCnt   <= (acqCnt == lastAcq) ? '0 : acqCnt + 1'b1;
                    end
                    else begin
                        curPixel <= curPixel + 1'b1;
                    end
                end
                else begin
                    sampleCnt <= sampleCnt + 1'b1;
                end
                busy <= passLast;
            end
            else if (busy && (pass != seenPass)) begin
                busy     <= 1'b0;        // Window calculator finished its scan
                seenPass <= pass;
            end
        end
    end

    // Valid bits and strobes
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid    <= '0;
            countStrobe <= 1'b0;
            passEnd     <= 1'b0;
        end
        else begin
            countStrobe <= accept && binKeep;
            passEnd     <= accept && passLast;
            if (passEnd) begin
                binValid <= '0;          // Lazy clear of every histogram
            end
            else if (accept && binKeep) begin
                binValid[curPixel][binAddr] <= 1'b1;
            end
        end
    end

    // Counter storage and payload to the peak detector
    always_ff @(posedge clk) begin
        if (accept && binKeep) begin
            binCount[curPixel][binAddr] <= newCount;
        end
        if (accept) begin
            countPixel <= curPixel;
            countBin   <= binAddr;
            countValue <= newCount;
        end
    end

endmodule

// File: histogram/peakDetector.sv
// Running maximum count and peak bin per pixel
// Pass-end pulse towards the window calculator
`timescale 1ns/10ps

module peakDetector #(
    parameter int pixelNum = sifhCfgPkg::defaultPixels
) (
    input  logic                                      clk,
    input  logic                                      combin_res,
    input  logic                                      countStrobe,
    input  logic [sifhCfgPkg::idxWidth(pixelNum)-1:0] countPixel,
    input  logic [sifhCfgPkg::binBits-1:0]            countBin,
    input  logic [sifhCfgPkg::countBits-1:0]          countValue,
    input  logic                                      passEnd,
    output logic                                      peakDone,
    input  logic [sifhCfgPkg::idxWidth(pixelNum)-1:0] peakSel,
    output logic [sifhCfgPkg::binBits-1:0]            peakSelBin
);
    import sifhCfgPkg::*;

    logic [countBits-1:0] maxCount [pixelNum];
    logic [binBits-1:0]   maxBin   [pixelNum];

    // Read port for the window scan
    assign peakSelBin = maxBin[peakSel];

    // ********************
    // Peak tracking
    // ********************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            peakDone <= 1'b0;
            for (int p = 0; p < pixelNum; p++) begin
                maxCount[p] <= '0;
                maxBin[p]   <= '0;
            end
        end
        else begin
            peakDone <= passEnd;
            if (peakDone) begin
                // Bins stay for the scan, the next pass overwrites them
                for (int p = 0; p < pixelNum; p++) begin
                    maxCount[p] <= '0;
                end
            end
            else if (countStrobe && (countValue > maxCount[countPixel])) begin
                maxCount[countPixel] <= countValue;   // Strictly greater only
                maxBin[countPixel]   <= countBin;
            end
        end
    end

endmodule

// File: source/windowCalculator.sv
// Fine window calculation from coarse peaks with range clamp
// Final result output and pass control
`timescale 1ns/10ps

module windowCalculator #(
    parameter int pixelNum = sifhCfgPkg::defaultPixels
) (
    input  logic                                      clk,
    input  logic                                      combin_res,
    input  logic                                      peakDone,
    input  logic [sifhCfgPkg::idxWidth(pixelNum)-1:0] curPixel,
    input  logic [sifhCfgPkg::binBits-1:0]            peakSelBin,
    output logic [sifhCfgPkg::idxWidth(pixelNum)-1:0] peakSel,
    output logic [sifhCfgPkg::sampleBits-1:0]         winLow,
    output logic [sifhCfgPkg::sampleBits-1:0]         winHigh,
    output sifhTypesPkg::passSel_t                    pass,
    output logic                                      resultValid,
    output logic [sifhCfgPkg::idxWidth(pixelNum)-1:0] resultPixel,
    output logic [sifhCfgPkg::sampleBits-1:0]         resultValue
);
    import sifhCfgPkg::*;
    import sifhTypesPkg::*;

    localparam int pixBits = idxWidth(pixelNum);
    localparam logic [pixBits-1:0]    lastPixel = pixBits'(pixelNum - 1);
    localparam logic [sampleBits-1:0] halfWin   = sampleBits'(halfWindow);
    localparam logic [sampleBits-1:0] spanTop   = sampleBits'(windowSpan - 1);
    localparam logic [sampleBits-1:0] topLow    = sampleBits'(topLowBound);

    logic [sampleBits-1:0] winLowArr [pixelNum];
    logic                  scanActive;
    logic [pixBits-1:0]    scanIdx;
    sampleWord_t           centreWord;
    logic [sampleBits-1:0] lowerRaw;
    logic [sampleBits-1:0] lowerClamped;

    assign peakSel = scanIdx;
    assign winLow  = winLowArr[curPixel];
    assign winHigh = winLow + spanTop;

    // Coarse bin back to a code, then clamp the window to the code range
    always_comb begin
        centreWord.coarse.coarseBin = peakSelBin;
        centreWord.coarse.residue   = '0;
        lowerRaw     = (centreWord.raw < halfWin) ? '0 : centreWord.raw - halfWin;
        lowerClamped = (lowerRaw > topLow) ? topLow : lowerRaw;
    end

    // ********************
    // Pixel scan
    // ********************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            scanActive  <= 1'b0;
            scanIdx     <= '0;
            pass        <= passCoarse;
            resultValid <= 1'b0;
            for (int p = 0; p < pixelNum; p++) begin
                winLowArr[p] <= '0;
            end
        end
        else begin
            resultValid <= 1'b0;
            if (peakDone) begin
                scanActive <= 1'b1;
                scanIdx    <= '0;
            end
            else if (scanActive) begin
                if (pass == passCoarse) begin
                    winLowArr[scanIdx] <= lowerClamped;
                end
                else begin
                    resultValid <= 1'b1;                 // One pulse per pixel
                end
                if (scanIdx == lastPixel) begin
                    scanActive <= 1'b0;
                    scanIdx    <= '0;
                    pass       <= (pass == passCoarse) ? passFine : passCoarse;
                end
                else begin
                    scanIdx <= scanIdx + 1'b1;
                end
            end
        end
    end

    // Fine peak plus window floor gives the result code
    always_ff @(posedge clk) begin
        if (scanActive && !peakDone && (pass == passFine)) begin
            resultPixel <= scanIdx;
            resultValue <= winLowArr[scanIdx] + sampleBits'(peakSelBin);
        end
    end

endmodule

// File: source/sifhTop.sv
// Top level of the two-pass histogram peak finder
// Wires filter, histogram builder, peak detector and window calculator
`timescale 1ns/10ps

module sifhTop #(
    parameter int pixelNum            = sifhCfgPkg::defaultPixels,
    parameter int samplesPerPixel     = sifhCfgPkg::defaultSamplesPerPixel,
    parameter int acquisitionsPerPass = sifhCfgPkg::defaultAcquisitions
) (
    input  logic                                      clk,
    input  logic                                      combin_res,
    input  logic                                      wrEn,
    input  logic [sifhCfgPkg::sampleBits-1:0]         data,
    output logic                                      resultValid,
    output logic [sifhCfgPkg::idxWidth(pixelNum)-1:0] resultPixel,
    output logic [sifhCfgPkg::sampleBits-1:0]         resultValue,
    output sifhTypesPkg::passSel_t                    pass
);
    import sifhCfgPkg::*;

    localparam int pixBits = idxWidth(pixelNum);

    // Filter to builder
    logic [binBits-1:0]    binAddr;
    logic                  binKeep;
    logic [pixBits-1:0]    curPixel;

    // Builder to peak detector
    logic                  countStrobe;
    logic [pixBits-1:0]    countPixel;
    logic [binBits-1:0]    countBin;
    logic [countBits-1:0]  countValue;
    logic                  passEnd;

    // Peak detector and window calculator
    logic                  peakDone;
    logic [pixBits-1:0]    peakSel;
    logic [binBits-1:0]    peakSelBin;
    logic [sampleBits-1:0] winLow;
    logic [sampleBits-1:0] winHigh;

    dataFilter u_dataFilter (
        .data    (data),
        .pass    (pass),
        .winLow  (winLow),
        .winHigh (winHigh),
        .binAddr (binAddr),
        .binKeep (binKeep)
    );

    histogramBuilder #(
        .pixelNum            (pixelNum),
        .samplesPerPixel     (samplesPerPixel),
        .acquisitionsPerPass (acquisitionsPerPass)
    ) u_histogramBuilder (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .binAddr     (binAddr),
        .binKeep     (binKeep),
        .pass        (pass),
        .curPixel    (curPixel),
        .countStrobe (countStrobe),
        .countPixel  (countPixel),
        .countBin    (countBin),
        .countValue  (countValue),
        .passEnd     (passEnd),
        .busy        ()                  // Gap handled inside the builder
    );

    peakDetector #(
        .pixelNum (pixelNum)
    ) u_peakDetector (
        .clk         (clk),
        .combin_res  (combin_res),
        .countStrobe (countStrobe),
        .countPixel  (countPixel),
        .countBin    (countBin),
        .countValue  (countValue),
        .passEnd     (passEnd),
        .peakDone    (peakDone),
        .peakSel     (peakSel),
        .peakSelBin  (peakSelBin)
    );

    windowCalculator #(
        .pixelNum (pixelNum)
    ) u_windowCalculator (
        .clk         (clk),
        .combin_res  (combin_res),
        .peakDone    (peakDone),
        .curPixel    (curPixel),
        .peakSelBin  (peakSelBin),
        .peakSel     (peakSel),
        .winLow      (winLow),
        .winHigh     (winHigh),
        .pass        (pass),
        .resultValid (resultValid),
        .resultPixel (resultPixel),
        .resultValue (resultValue)
    );

endmodule

// File: testbench/sifhTb.sv
// Testbench for the two-pass histogram peak finder
// Clustered LCG stimulus, reference model of both passes, result checks
`timescale 1ns/10ps

module sifhTb;
    import sifhCfgPkg::*;
    import sifhTypesPkg::*;

    localparam int pixelNum  = defaultPixels;
    localparam int spp       = defaultSamplesPerPixel;
    localparam int acqNum    = defaultAcquisitions;
    localparam int passLen   = pixelNum * spp * acqNum;    // Samples in one pass
    localparam int pixBits   = idxWidth(pixelNum);
    localparam int shiftBits = sampleBits - binBits;
    localparam int waitLimit = 4 * pixelNum + 20;

    logic                  clk;
    logic                  combin_res;
    logic                  wrEn;
    logic [sampleBits-1:0] data;
    logic                  resultValid;
    logic [pixBits-1:0]    resultPixel;
    logic [sampleBits-1:0] resultValue;
    passSel_t              pass;

    logic [31:0] lcgState;
    int          coarseData [passLen];
    int          fineData   [passLen];
    int          lowExp     [pixelNum];
    int          resultExp  [pixelNum];
    int          pixQ [$];
    int          valQ [$];
    int          errCount;
    int          timeoutCount;
    int          monitorErrors;
    bit          firstPassOpen;
    bit          resultsExpected;

    sifhTop u_sifhTop (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .data        (data),
        .resultValid (resultValid),
        .resultPixel (resultPixel),
        .resultValue (resultValue),
        .pass        (pass)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ********************
    // Stimulus
    // ********************
    function automatic int nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return int'(lcgState[30:16]);   // Upper bits are less regular
    endfunction

    // Coarse bin that each pixel clusters on
    function automatic int targetBin(input int round, input int pix);
        case (round * 4 + pix)
            0: return 0;                // Low end of the code range
            1: return 22;
            2: return 63;               // High end of the code range
            3: return 40;
            4: return 50;
            5: return 7;
            6: return 1;
            default: return 0;
        endcase
    endfunction

    function automatic int tiePixel(input int round);
        return (round == 0) ? 3 : 1;
    endfunction

    function automatic int makeSample(input int round, input int pix, input int acq,
                                      input int k);
        int base;
        base = targetBin(round, pix) << shiftBits;
        if (pix == tiePixel(round)) begin
            // Two fine bins with equal totals and the higher bin reached first
            return (k % 2 == 0) ? base + 20 : base + 5;
        end
        else if ((acq % 2 == 1) && (k == spp - 1)) begin
            return nextRand() % (maxCode + 1);      // Stray hit
        end
        return base + nextRand() % 16;
    endfunction

    task automatic buildData(input int round);
        int acq;
        int pix;
        for (int i = 0; i < passLen; i++) begin
            acq = i / (pixelNum * spp);
            pix = (i / spp) % pixelNum;
            coarseData[i] = makeSample(round, pix, acq, i % spp);
        end
        for (int i = 0; i < passLen; i++) begin
            acq = i / (pixelNum * spp);
            pix = (i / spp) % pixelNum;
            fineData[i] = makeSample(round, pix, acq, i % spp);
        end
    endtask

    // ********************
    // Reference model
    // ********************

    // Peak bin of one pixel where a later bin must be strictly higher to win
    function automatic int peakOf(input int pix, input bit finePass);
        int counts [binsPerPixel];
        int best;
        int bestBin;
        int v;
        int b;
        best    = 0;
        bestBin = 0;
        foreach (counts[j]) begin
            counts[j] = 0;
        end
        for (int i = 0; i < passLen; i++) begin
            if ((i / spp) % pixelNum == pix) begin
                v = finePass ? fineData[i] : coarseData[i];
                b = finePass ? v - lowExp[pix] : v >> shiftBits;
                if (!finePass || ((b >= 0) && (b < windowSpan))) begin
                    if (counts[b] < (1 << countBits) - 1) begin
                        counts[b]++;                // Saturating count
                    end
                    if (counts[b] > best) begin
                        best    = counts[b];
                        bestBin = b;
                    end
                end
            end
        end
        return bestBin;
    endfunction

    function automatic int windowLow(input int coarseBin);
        int centre;
        int low;
        centre = coarseBin << shiftBits;
        low    = (centre < halfWindow) ? 0 : centre - halfWindow;
        if (low + windowSpan - 1 > maxCode) begin
            low = maxCode - windowSpan + 1;
        end
        return low;
    endfunction

    // ********************
    // Driving and checking
    // ********************
    task automatic sendPass(input bit finePass);
        for (int i = 0; i < passLen; i++) begin
            @(posedge clk);
            wrEn <= 1'b1;
            data <= sampleBits'(finePass ? fineData[i] : coarseData[i]);
        end
        @(posedge clk);
        wrEn <= 1'b0;
    endtask

    task automatic waitForPass(input passSel_t target, input string what);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while ((pass != target) && (cycles < waitLimit));
        assert (pass == target) else begin
            timeoutCount++;
            $display("Timeout: pass did not change after %s", what);
        end
    endtask

    // Gathers the result pulses of one fine scan
    task automatic collectResults();
        int cycles;
        cycles = 0;
        pixQ.delete();
        valQ.delete();
        do begin
            @(negedge clk);
            if (resultValid) begin
                pixQ.push_back(int'(resultPixel));
                valQ.push_back(int'(resultValue));
            end
            cycles++;
        end while (((pixQ.size() < pixelNum) || (pass != passCoarse)) && (cycles < waitLimit));
        assert ((pixQ.size() == pixelNum) && (pass == passCoarse)) else begin
            timeoutCount++;
            $display("Timeout: got %0d of %0d results before the pass returned to coarse",
                     pixQ.size(), pixelNum);
        end
    endtask

    task automatic expectEqual(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            errCount++;
            $display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    // One coarse pass and one fine pass with fresh data
    task automatic runRound(input int round);
        buildData(round);
        for (int p = 0; p < pixelNum; p++) begin
            lowExp[p]    = windowLow(peakOf(p, 1'b0));
            resultExp[p] = lowExp[p] + peakOf(p, 1'b1);
        end
        sendPass(1'b0);
        firstPassOpen = 1'b0;
        waitForPass(passFine, "the coarse pass");
        sendPass(1'b1);
        resultsExpected = 1'b1;
        collectResults();
        @(posedge clk);                 // Last pulse ends on this edge
        resultsExpected = 1'b0;
        for (int p = 0; p < pixQ.size(); p++) begin
            expectEqual($sformatf("round %0d result %0d pixel", round, p), p, pixQ[p]);
            expectEqual($sformatf("round %0d pixel %0d value", round, p),
                        resultExp[p], valQ[p]);
        end
    endtask

    // No result pulse outside a fine scan and coarse level through the first pass
    always @(negedge clk) begin
        if (combin_res && !resultsExpected) begin
            assert (!resultValid) else begin
                monitorErrors++;
                $display("[FAIL] resultValid outside a fine scan expected 0 actual 1");
            end
        end
        if (firstPassOpen) begin
            assert (pass == passCoarse) else begin
                monitorErrors++;
                $display("[FAIL] pass during first coarse pass expected %0d actual %0d",
                         passCoarse, pass);
            end
        end
    end

    initial begin
        lcgState        = 32'h5cd7;
        errCount        = 0;
        timeoutCount    = 0;
        monitorErrors   = 0;
        firstPassOpen   = 1'b0;
        resultsExpected = 1'b0;
        combin_res      = 1'b0;
        wrEn            = 1'b0;
        data            = '0;
        repeat (4) @(posedge clk);
        combin_res    <= 1'b1;
        firstPassOpen = 1'b1;
        runRound(0);
        runRound(1);                    // Needs cleared histograms from round 0
        $display("Errors: %0d mismatches, %0d timeouts", errCount + monitorErrors,
                 timeoutCount);
        if ((errCount + monitorErrors + timeoutCount) == 0) begin
            $display("Simulation completed successfully");
        end
        else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: build.f
common/sifhCfgPkg.sv
common/sifhTypesPkg.sv
histogram/dataFilter.sv
histogram/histogramBuilder.sv
histogram/peakDetector.sv
source/windowCalculator.sv
source/sifhTop.sv
testbench/sifhTb.sv

// File: run.sh
#!/bin/sh
# Verilator build and run of the histogram peak finder testbench

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --assert --timescale 1ns/10ps --top-module sifhTb \
    -f build.f -o sifhSim > build.log 2>&1 \
    && ./obj_dir/sifhSim > sim.log 2>&1 \
    || echo "Compile or simulation exited with an error, see build.log and sim.log"

cat sim.log 2>/dev/null

grep -qx "Simulation completed successfully" sim.log 2>/dev/null \
    && echo "RESULT: PASS" \
    || { echo "RESULT: FAIL"; exit 1; }
